//--- common/gcu_pkg.sv
/*
 * shared widths, types, register numbers, layer address map and raster
 * constants of the graphics controller core; imported by every RTL block
 */
`default_nettype none

package gcu_pkg;

    // cpu bus and ram word
    localparam int WORD_W = 16;
    typedef logic [WORD_W-1:0] word_t;

    // main video ram, the pointer lives at this width
    localparam int VRAM_AW = 13;
    typedef logic [VRAM_AW-1:0] vram_addr_t;

    localparam int SCROLL_AW = 11;
    localparam int SPRITE_AW = 10;

    // low 13 bits of the written word, signed
    localparam int SCROLL_W = 13;
    typedef logic signed [SCROLL_W-1:0] scroll_t;

    localparam int POS_W = 9;

    // register numbers, bit 7 aliases the layer registers
    localparam logic [7:0] REG_NUM_MASK  = 8'h8F;
    localparam logic [7:0] REG_BG_X      = 8'h00;
    localparam logic [7:0] REG_BG_Y      = 8'h01;
    localparam logic [7:0] REG_FG_X      = 8'h02;
    localparam logic [7:0] REG_FG_Y      = 8'h03;
    localparam logic [7:0] REG_TXT_X     = 8'h04;
    localparam logic [7:0] REG_TXT_Y     = 8'h05;
    localparam logic [7:0] REG_SPR_X     = 8'h06;
    localparam logic [7:0] REG_SPR_Y     = 8'h07;
    localparam logic [7:0] REG_IRQ_ACK_A = 8'h0E;
    localparam logic [7:0] REG_IRQ_ACK_B = 8'h0F;
    localparam logic [7:0] REG_IRQ_ACK_C = 8'h8F;

    // layer map inside the main ram; above SPR_END only the main ram is written
    localparam vram_addr_t SCR0_BASE = 13'h0000;
    localparam vram_addr_t SCR1_BASE = 13'h0800;
    localparam vram_addr_t SCR2_BASE = 13'h1000;
    localparam vram_addr_t SPR_BASE  = 13'h1800;
    localparam vram_addr_t SPR_END   = 13'h1C00;

    // line where the vertical interrupt fires
    localparam logic [POS_W-1:0] VINT_LINE = 9'h0E6;

    // per-layer scroll offsets, consumed by the renderers
    localparam scroll_t BG_XOFFS  = -13'sh1D6;
    localparam scroll_t BG_YOFFS  = -13'sh1EF;
    localparam scroll_t FG_XOFFS  = -13'sh1D8;
    localparam scroll_t FG_YOFFS  = -13'sh1EF;
    localparam scroll_t TXT_XOFFS = -13'sh1DA;
    localparam scroll_t TXT_YOFFS = -13'sh1EF;
    localparam scroll_t SPR_XOFFS = 13'sh024;
    localparam scroll_t SPR_YOFFS = 13'sh001;

endpackage

`default_nettype wire

//--- common/vram_if.sv
/*
 * video ram access port between the cpu bus controller (host)
 * and the ram block (mem); rdata follows addr by one clock
 */
`timescale 1ns/1ns
`default_nettype none

interface vram_if;
    import gcu_pkg::*;

    logic       we;
    vram_addr_t addr;
    word_t      wdata;
    word_t      rdata;

    modport host (output we, output addr, output wdata, input rdata);
    modport mem (input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- hw/cpu_bus/gcu_bus_ctrl.sv
/*
 * cpu side of the video ram: pointer load, write with auto-increment,
 * and the three-step read. ack is low while a ram access is in flight
 */
`timescale 1ns/1ns
`default_nettype none

module gcu_bus_ctrl (
    input  logic           CLK96,
    input  logic           RESET96,
    input  gcu_pkg::word_t din,
    input  logic           op_set_ram_ptr,
    input  logic           op_write_ram,
    input  logic           op_read_ram_h,
    input  logic           op_read_ram_l,
    output gcu_pkg::word_t dout,
    output logic           ack,
    vram_if.host           vram
);
    import gcu_pkg::*;

    // read sequence steps
    localparam logic [1:0] RD_IDLE = 2'd0;
    localparam logic [1:0] RD_WAIT = 2'd1;
    localparam logic [1:0] RD_LOAD = 2'd2;

    logic [3:0] cmd;
    logic [3:0] last_cmd;
    logic       new_cmd;
    logic       rd_cmd;
    logic [1:0] rd_st;
    vram_addr_t ptr;

    assign cmd     = {op_set_ram_ptr, op_write_ram, op_read_ram_h, op_read_ram_l};
    assign new_cmd = cmd != last_cmd;
    assign rd_cmd  = op_read_ram_h || op_read_ram_l;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            last_cmd <= '0;
            ptr      <= '0;
            rd_st    <= RD_IDLE;
            ack      <= 1'b1;
            vram.we  <= 1'b0;
        end else begin
            last_cmd <= cmd;
            if (new_cmd) begin
                // a fresh command level restarts the sequence
                vram.we <= op_write_ram;
                ack     <= !(op_write_ram || rd_cmd);
                rd_st   <= rd_cmd ? RD_WAIT : RD_IDLE;
                if (op_set_ram_ptr) begin
                    ptr <= din[VRAM_AW-1:0];
                end
            end else if (vram.we) begin
                // write lands this edge, step to the next word
                vram.we <= 1'b0;
                ack     <= 1'b1;
                ptr     <= ptr + 1'b1;
            end else if (rd_st == RD_WAIT) begin
                rd_st <= RD_LOAD;
            end else if (rd_st == RD_LOAD) begin
                ack   <= 1'b1;
                rd_st <= RD_IDLE;
            end
        end
    end

    // address, write data and read result
    always_ff @(posedge CLK96) begin
        if (new_cmd && op_write_ram) begin
            vram.addr  <= ptr;
            vram.wdata <= din;
        end else if (new_cmd && rd_cmd) begin
            // read low takes the word after the pointer
            vram.addr <= ptr + vram_addr_t'(op_read_ram_l);
        end
        if (!new_cmd && rd_st == RD_LOAD) begin
            dout <= vram.rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_bus/scroll_regs.sv
/*
 * register select and write path: holds the selected number, the eight
 * layer scroll registers, and pulses irq_ack when an ack number is selected
 */
`timescale 1ns/1ns
`default_nettype none

module scroll_regs (
    input  logic             CLK96,
    input  logic             RESET96,
    input  gcu_pkg::word_t   din,
    input  logic             op_select_reg,
    input  logic             op_write_reg,
    output gcu_pkg::scroll_t bg_scroll_x,
    output gcu_pkg::scroll_t bg_scroll_y,
    output gcu_pkg::scroll_t fg_scroll_x,
    output gcu_pkg::scroll_t fg_scroll_y,
    output gcu_pkg::scroll_t txt_scroll_x,
    output gcu_pkg::scroll_t txt_scroll_y,
    output gcu_pkg::scroll_t spr_scroll_x,
    output gcu_pkg::scroll_t spr_scroll_y,
    output logic             irq_ack
);
    import gcu_pkg::*;

    logic [7:0] reg_num;
    logic [7:0] sel_num;
    logic [7:0] dec_num;
    logic       sel_q;
    logic       sel_is_ack;
    scroll_t    wr_val;

    assign sel_num    = din[7:0] & REG_NUM_MASK;
    assign sel_is_ack = sel_num == REG_IRQ_ACK_A || sel_num == REG_IRQ_ACK_B
                        || sel_num == REG_IRQ_ACK_C;
    // bit 7 selects the same layer register
    assign dec_num    = {1'b0, reg_num[6:0]};
    assign wr_val     = scroll_t'(din[SCROLL_W-1:0]);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_num      <= '0;
            sel_q        <= 1'b0;
            irq_ack      <= 1'b0;
            bg_scroll_x  <= '0;
            bg_scroll_y  <= '0;
            fg_scroll_x  <= '0;
            fg_scroll_y  <= '0;
            txt_scroll_x <= '0;
            txt_scroll_y <= '0;
            spr_scroll_x <= '0;
            spr_scroll_y <= '0;
        end else begin
            sel_q <= op_select_reg;
            // one pulse per select, not per held cycle
            irq_ack <= op_select_reg && !sel_q && sel_is_ack;
            if (op_select_reg) begin
                reg_num <= sel_num;
            end
            if (op_write_reg) begin
                case (dec_num)
                    REG_BG_X:  bg_scroll_x  <= wr_val;
                    REG_BG_Y:  bg_scroll_y  <= wr_val;
                    REG_FG_X:  fg_scroll_x  <= wr_val;
                    REG_FG_Y:  fg_scroll_y  <= wr_val;
                    REG_TXT_X: txt_scroll_x <= wr_val;
                    REG_TXT_Y: txt_scroll_y <= wr_val;
                    REG_SPR_X: spr_scroll_x <= wr_val;
                    REG_SPR_Y: spr_scroll_y <= wr_val;
                    // other numbers have no register here
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/gcu_top.sv
/*
 * cpu-facing core of the tile and sprite graphics controller
 * ties the bus controller, scroll registers, raster logic and video ram together
 */
`timescale 1ns/1ns
`default_nettype none

module gcu_top (
    input  logic                          CLK96,
    input  logic                          RESET96,

    // cpu bus
    input  gcu_pkg::word_t                din,
    output gcu_pkg::word_t                dout,
    output logic                          ack,
    input  logic                          op_select_reg,
    input  logic                          op_write_reg,
    input  logic                          op_set_ram_ptr,
    input  logic                          op_write_ram,
    input  logic                          op_read_ram_h,
    input  logic                          op_read_ram_l,

    // raster
    input  logic [gcu_pkg::POS_W-1:0]     h,
    input  logic [gcu_pkg::POS_W-1:0]     v,
    input  logic [gcu_pkg::POS_W-1:0]     hs_start,
    input  logic [gcu_pkg::POS_W-1:0]     hs_end,
    input  logic [gcu_pkg::POS_W-1:0]     vs_start,
    input  logic [gcu_pkg::POS_W-1:0]     vs_end,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          fblank,
    output logic                          vint,

    // scroll values
    output gcu_pkg::scroll_t              bg_scroll_x,
    output gcu_pkg::scroll_t              bg_scroll_y,
    output gcu_pkg::scroll_t              fg_scroll_x,
    output gcu_pkg::scroll_t              fg_scroll_y,
    output gcu_pkg::scroll_t              txt_scroll_x,
    output gcu_pkg::scroll_t              txt_scroll_y,
    output gcu_pkg::scroll_t              spr_scroll_x,
    output gcu_pkg::scroll_t              spr_scroll_y,

    // renderer read ports
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr0_addr,
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr1_addr,
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr2_addr,
    output gcu_pkg::word_t                scr0_data,
    output gcu_pkg::word_t                scr1_data,
    output gcu_pkg::word_t                scr2_data,
    input  logic [gcu_pkg::SPRITE_AW-1:0] spr_addr,
    output gcu_pkg::word_t                spr_data
);

    logic irq_ack;

    vram_if u_vram_if ();

    gcu_bus_ctrl u_bus_ctrl (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .din            (din),
        .op_set_ram_ptr (op_set_ram_ptr),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .dout           (dout),
        .ack            (ack),
        .vram           (u_vram_if.host)
    );

    scroll_regs u_scroll_regs (
        .CLK96         (CLK96),
        .RESET96       (RESET96),
        .din           (din),
        .op_select_reg (op_select_reg),
        .op_write_reg  (op_write_reg),
        .bg_scroll_x   (bg_scroll_x),
        .bg_scroll_y   (bg_scroll_y),
        .fg_scroll_x   (fg_scroll_x),
        .fg_scroll_y   (fg_scroll_y),
        .txt_scroll_x  (txt_scroll_x),
        .txt_scroll_y  (txt_scroll_y),
        .spr_scroll_x  (spr_scroll_x),
        .spr_scroll_y  (spr_scroll_y),
        .irq_ack       (irq_ack)
    );

    raster_ctrl u_raster_ctrl (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .h        (h),
        .v        (v),
        .hs_start (hs_start),
        .hs_end   (hs_end),
        .vs_start (vs_start),
        .vs_end   (vs_end),
        .irq_ack  (irq_ack),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank),
        .vint     (vint)
    );

    gcu_vram u_vram (
        .CLK96     (CLK96),
        .vram      (u_vram_if.mem),
        .scr0_addr (scr0_addr),
        .scr1_addr (scr1_addr),
        .scr2_addr (scr2_addr),
        .scr0_data (scr0_data),
        .scr1_data (scr1_data),
        .scr2_data (scr2_data),
        .spr_addr  (spr_addr),
        .spr_data  (spr_data)
    );

endmodule

`default_nettype wire

//--- hw/raster_ctrl.sv
/*
 * sync and blank compares against the programmed bounds, and the
 * active-low vertical interrupt raised at VINT_LINE
 */
`timescale 1ns/1ns
`default_nettype none

module raster_ctrl (
    input  logic                      CLK96,
    input  logic                      RESET96,
    input  logic [gcu_pkg::POS_W-1:0] h,
    input  logic [gcu_pkg::POS_W-1:0] v,
    input  logic [gcu_pkg::POS_W-1:0] hs_start,
    input  logic [gcu_pkg::POS_W-1:0] hs_end,
    input  logic [gcu_pkg::POS_W-1:0] vs_start,
    input  logic [gcu_pkg::POS_W-1:0] vs_end,
    input  logic                      irq_ack,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      fblank,
    output logic                      vint
);
    import gcu_pkg::*;

    // hsync window is open at both ends, vsync window closed
    assign hsync  = !(h > hs_start && h < hs_end);
    assign vsync  = !(v >= vs_start && v <= vs_end);
    assign fblank = hsync && vsync;

    // ack wins over the interrupt line
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vint <= 1'b1;
        end else if (irq_ack) begin
            vint <= 1'b1;
        end else if (v == VINT_LINE) begin
            vint <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/vram/dual_port_ram.sv
/*
 * one write port, one read port ram of 16-bit words
 * read data is registered, valid one clock after raddr
 */
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  gcu_pkg::word_t    wdata,
    input  logic [ADDR_W-1:0] raddr,
    output gcu_pkg::word_t    rdata
);
    import gcu_pkg::*;

    word_t mem [2**ADDR_W];

    // same-address read returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- hw/vram/gcu_vram.sv
/*
 * main video ram plus the per-layer copies the renderers read from
 * every cpu write goes to the main ram and to at most one layer ram
 */
`timescale 1ns/1ns
`default_nettype none

module gcu_vram (
    input  logic                          CLK96,
    vram_if.mem                           vram,
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr0_addr,
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr1_addr,
    input  logic [gcu_pkg::SCROLL_AW-1:0] scr2_addr,
    output gcu_pkg::word_t                scr0_data,
    output gcu_pkg::word_t                scr1_data,
    output gcu_pkg::word_t                scr2_data,
    input  logic [gcu_pkg::SPRITE_AW-1:0] spr_addr,
    output gcu_pkg::word_t                spr_data
);
    import gcu_pkg::*;

    logic [VRAM_AW-SCROLL_AW-1:0] page;
    logic                         scr0_we;
    logic                         scr1_we;
    logic                         scr2_we;
    logic                         spr_we;

    // scroll maps fill whole 2K pages
    assign page    = vram.addr[VRAM_AW-1:SCROLL_AW];
    assign scr0_we = vram.we && page == SCR0_BASE[VRAM_AW-1:SCROLL_AW];
    assign scr1_we = vram.we && page == SCR1_BASE[VRAM_AW-1:SCROLL_AW];
    assign scr2_we = vram.we && page == SCR2_BASE[VRAM_AW-1:SCROLL_AW];
    // sprite table is only half of the last page
    assign spr_we  = vram.we && vram.addr >= SPR_BASE && vram.addr < SPR_END;

    // cpu read-back comes from the main copy
    dual_port_ram #(.ADDR_W(VRAM_AW)) u_main_ram (
        .clk   (CLK96),
        .we    (vram.we),
        .waddr (vram.addr),
        .wdata (vram.wdata),
        .raddr (vram.addr),
        .rdata (vram.rdata)
    );

    dual_port_ram #(.ADDR_W(SCROLL_AW)) u_scr0_ram (
        .clk   (CLK96),
        .we    (scr0_we),
        .waddr (vram.addr[SCROLL_AW-1:0]),
        .wdata (vram.wdata),
        .raddr (scr0_addr),
        .rdata (scr0_data)
    );

    dual_port_ram #(.ADDR_W(SCROLL_AW)) u_scr1_ram (
        .clk   (CLK96),
        .we    (scr1_we),
        .waddr (vram.addr[SCROLL_AW-1:0]),
        .wdata (vram.wdata),
        .raddr (scr1_addr),
        .rdata (scr1_data)
    );

    dual_port_ram #(.ADDR_W(SCROLL_AW)) u_scr2_ram (
        .clk   (CLK96),
        .we    (scr2_we),
        .waddr (vram.addr[SCROLL_AW-1:0]),
        .wdata (vram.wdata),
        .raddr (scr2_addr),
        .rdata (scr2_data)
    );

    dual_port_ram #(.ADDR_W(SPRITE_AW)) u_spr_ram (
        .clk   (CLK96),
        .we    (spr_we),
        .waddr (vram.addr[SPRITE_AW-1:0]),
        .wdata (vram.wdata),
        .raddr (spr_addr),
        .rdata (spr_data)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+testbench
common/gcu_pkg.sv
common/vram_if.sv
hw/vram/dual_port_ram.sv
hw/vram/gcu_vram.sv
hw/raster_ctrl.sv
hw/cpu_bus/scroll_regs.sv
hw/cpu_bus/gcu_bus_ctrl.sv
hw/gcu_top.sv
testbench/tb_gcu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_gcu -f list.f -o sim_gcu
./obj_dir/sim_gcu

//--- testbench/tb_gcu_cases.svh
/*
 * stimulus table for the graphics controller testbench,
 * included inside the testbench module and applied in order
 */

typedef enum int {K_RESET, K_SCROLL, K_RAM, K_LAYER, K_SYNC, K_VINT} kind_t;

typedef struct packed {
    kind_t       kind;
    logic [63:0] data;
    logic [31:0] addr;
    logic [31:0] exp;
} case_t;

localparam int N_CASES = 27;

// columns: kind, data, addr, expected
// K_SCROLL  din word, register number, unused
// K_RAM     number of words, start pointer, unused
// K_LAYER   unused, vram address, port index (4 means sprite port unchanged)
// K_SYNC    {hs_start, hs_end, vs_start, vs_end}, {h, v}, {hsync, vsync, fblank}
// K_VINT    unused, acknowledge register number, unused
case_t cases [N_CASES] = '{
    '{K_RESET,  64'h0,                 32'h0,         32'h0},
    '{K_SCROLL, 64'h0123,              32'h00,        32'h0},
    '{K_SCROLL, 64'hF456,              32'h01,        32'h0},
    '{K_SCROLL, 64'h1FFF,              32'h02,        32'h0},
    '{K_SCROLL, 64'h0ABC,              32'h03,        32'h0},
    '{K_SCROLL, 64'h1000,              32'h04,        32'h0},
    '{K_SCROLL, 64'h7001,              32'h05,        32'h0},
    '{K_SCROLL, 64'h0055,              32'h06,        32'h0},
    '{K_SCROLL, 64'hE1AA,              32'h07,        32'h0},
    '{K_SCROLL, 64'h0333,              32'h83,        32'h0},
    '{K_SCROLL, 64'h1444,              32'h03,        32'h0},
    '{K_SCROLL, 64'h0BAD,              32'h0A,        32'h0},
    '{K_RAM,    64'd4,                 32'h1E00,      32'h0},
    '{K_RAM,    64'd3,                 32'h1D80,      32'h0},
    '{K_LAYER,  64'h0,                 32'h0005,      32'd0},
    '{K_LAYER,  64'h0,                 32'h0805,      32'd1},
    '{K_LAYER,  64'h0,                 32'h1005,      32'd2},
    '{K_LAYER,  64'h0,                 32'h1805,      32'd3},
    '{K_LAYER,  64'h0,                 32'h1C05,      32'd4},
    '{K_SYNC,   64'h0010_0020_0008_000A, 32'h0010_0000, 32'b111},
    '{K_SYNC,   64'h0010_0020_0008_000A, 32'h0011_0000, 32'b010},
    '{K_SYNC,   64'h0010_0020_0008_000A, 32'h001F_0008, 32'b000},
    '{K_SYNC,   64'h0010_0020_0008_000A, 32'h0020_000A, 32'b100},
    '{K_SYNC,   64'h0010_0020_0008_000A, 32'h0005_000B, 32'b111},
    '{K_VINT,   64'h0,                 32'h8F,        32'h0},
    '{K_VINT,   64'h0,                 32'h0F,        32'h0},
    '{K_VINT,   64'h0,                 32'h0E,        32'h0}
};

//--- testbench/tb_gcu.sv
/*
 * testbench for the graphics controller core
 * applies the case table to the cpu bus, raster inputs and renderer ports
 * and checks each response
 */
`timescale 1ns/1ns
`default_nettype none

module tb_gcu;
    import gcu_pkg::*;

    localparam int TIMEOUT = 40;

    logic CLK96 = 1'b0;
    logic RESET96;
    word_t din, dout;
    logic ack, op_select_reg, op_write_reg, op_set_ram_ptr;
    logic op_write_ram, op_read_ram_h, op_read_ram_l;
    logic [POS_W-1:0] h, v, hs_start, hs_end, vs_start, vs_end;
    logic hsync, vsync, fblank, vint;
    scroll_t bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y;
    scroll_t txt_scroll_x, txt_scroll_y, spr_scroll_x, spr_scroll_y;
    logic [SCROLL_AW-1:0] scr0_addr, scr1_addr, scr2_addr;
    logic [SPRITE_AW-1:0] spr_addr;
    word_t scr0_data, scr1_data, scr2_data, spr_data;

    `include "tb_gcu_cases.svh"

    logic [31:0] rng_state;
    word_t       ram_model [int];
    word_t       spr_model [int];
    scroll_t     scroll_model [8];
    int          ptr_model;

    gcu_top dut (.*);

    always #50 CLK96 = ~CLK96;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_run(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic stop_timeout(input string what);
        $display("timed out at %0t ns waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic next_word(output word_t w);
        rng_state = xorshift(rng_state);
        w = rng_state[15:0];
    endtask

    // polls one output at each falling edge until it reaches the level
    task automatic wait_level(input int sel, input logic level, input string what);
        int n;
        n = 0;
        @(negedge CLK96);
        while ((sel == 0 ? ack : vint) !== level) begin
            if (n == TIMEOUT) stop_timeout(what);
            n++;
            @(negedge CLK96);
        end
    endtask

    task automatic ram_cmd(input int which, input word_t d);
        @(posedge CLK96);
        din           <= d;
        op_write_ram  <= (which == 1);
        op_read_ram_h <= (which == 2);
        op_read_ram_l <= (which == 3);
        wait_level(0, 1'b0, "ack to fall");
        wait_level(0, 1'b1, "ack to rise");
        @(posedge CLK96);
        op_write_ram  <= 1'b0;
        op_read_ram_h <= 1'b0;
        op_read_ram_l <= 1'b0;
    endtask

    task automatic set_ptr(input int p);
        @(posedge CLK96);
        op_set_ram_ptr <= 1'b1;
        din            <= word_t'(p);
        @(posedge CLK96);
        op_set_ram_ptr <= 1'b0;
        @(negedge CLK96);
        assert (ack === 1'b1) else fail_run("ack dropped on pointer load");
        ptr_model = p;
    endtask

    task automatic ram_write();
        word_t w;
        next_word(w);
        ram_cmd(1, w);
        ram_model[ptr_model] = w;
        ptr_model = (ptr_model + 1) % 8192;
    endtask

    task automatic ram_read(input logic low);
        word_t exp;
        exp = ram_model[(ptr_model + int'(low)) % 8192];
        ram_cmd(low ? 3 : 2, '0);
        assert (dout === exp) else
            fail_run($sformatf("read %s got %h expected %h", low ? "low" : "high", dout, exp));
    endtask

    task automatic check_scroll();
        scroll_t got [8];
        got = '{bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y,
                txt_scroll_x, txt_scroll_y, spr_scroll_x, spr_scroll_y};
        for (int i = 0; i < 8; i++) begin
            assert (got[i] === scroll_model[i]) else
                fail_run($sformatf("scroll %0d got %h expected %h", i, got[i],
                                   scroll_model[i]));
        end
    endtask

    task automatic scroll_case(input case_t c);
        logic [7:0] num;
        num = c.addr[7:0] & 8'h8F;
        @(posedge CLK96);
        op_select_reg <= 1'b1;
        din           <= word_t'(c.addr);
        @(posedge CLK96);
        op_select_reg <= 1'b0;
        op_write_reg  <= 1'b1;
        din           <= c.data[15:0];
        @(posedge CLK96);
        op_write_reg <= 1'b0;
        // bit 7 of the number aliases the layer registers
        if ((num & 8'h7F) < 8'd8) scroll_model[num[2:0]] = c.data[12:0];
        @(negedge CLK96);
        check_scroll();
    endtask

    task automatic layer_case(input case_t c);
        int k;
        word_t w;
        set_ptr(int'(c.addr));
        next_word(w);
        ram_cmd(1, w);
        ram_model[ptr_model] = w;
        ptr_model = (ptr_model + 1) % 8192;
        k = int'(c.addr) % 2048;
        @(posedge CLK96);
        scr0_addr <= k[SCROLL_AW-1:0];
        scr1_addr <= k[SCROLL_AW-1:0];
        scr2_addr <= k[SCROLL_AW-1:0];
        spr_addr  <= c.addr[SPRITE_AW-1:0];
        @(posedge CLK96);
        @(negedge CLK96);
        case (c.exp)
            0: assert (scr0_data === w) else fail_run("scroll 0 port word wrong");
            1: assert (scr1_data === w) else fail_run("scroll 1 port word wrong");
            2: assert (scr2_data === w) else fail_run("scroll 2 port word wrong");
            3: begin
                assert (spr_data === w) else fail_run("sprite port word wrong");
                spr_model[int'(c.addr[SPRITE_AW-1:0])] = w;
            end
            default: assert (spr_data === spr_model[int'(c.addr[SPRITE_AW-1:0])]) else
                fail_run("sprite port changed by write above the sprite table");
        endcase
    endtask

    task automatic run_case(input case_t c);
        case (c.kind)
            K_RESET: begin
                assert (ack === 1'b1 && vint === 1'b1) else fail_run("ack or vint low after reset");
                check_scroll();
            end
            K_SCROLL: scroll_case(c);
            K_RAM: begin
                set_ptr(int'(c.addr));
                repeat (int'(c.data) + 1) ram_write();
                set_ptr(int'(c.addr));
                for (int k = 0; k < int'(c.data); k++) begin
                    ram_read(1'b0);
                    ram_read(1'b1);
                    ram_write();
                end
            end
            K_LAYER: layer_case(c);
            K_SYNC: begin
                @(posedge CLK96);
                {hs_start, hs_end, vs_start, vs_end} <= {c.data[56:48], c.data[40:32],
                                                         c.data[24:16], c.data[8:0]};
                h <= c.addr[24:16];
                v <= c.addr[8:0];
                @(negedge CLK96);
                assert ({hsync, vsync, fblank} === c.exp[2:0]) else
                    fail_run($sformatf("sync got %b expected %b", {hsync, vsync, fblank},
                                       c.exp[2:0]));
            end
            default: begin
                @(posedge CLK96);
                v <= VINT_LINE;
                wait_level(1, 1'b0, "vint to go low");
                @(posedge CLK96);
                v <= '0;
                // leaving the line alone must not release the interrupt
                @(posedge CLK96);
                @(negedge CLK96);
                assert (vint === 1'b0) else fail_run("vint rose before the acknowledge");
                @(posedge CLK96);
                op_select_reg <= 1'b1;
                din           <= word_t'(c.addr);
                @(posedge CLK96);
                op_select_reg <= 1'b0;
                wait_level(1, 1'b1, "vint to be acknowledged");
            end
        endcase
    endtask

    initial begin
        rng_state = 32'd82136;
        ptr_model = 0;
        for (int i = 0; i < 8; i++) scroll_model[i] = '0;
        RESET96 = 1'b1;
        din = '0;
        op_select_reg = 1'b0;
        op_write_reg = 1'b0;
        op_set_ram_ptr = 1'b0;
        op_write_ram = 1'b0;
        op_read_ram_h = 1'b0;
        op_read_ram_l = 1'b0;
        {h, v, hs_start, hs_end, vs_start, vs_end} = '0;
        {scr0_addr, scr1_addr, scr2_addr, spr_addr} = '0;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        for (int i = 0; i < N_CASES; i++) run_case(cases[i]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
